// File: design/cdc_pkg.sv
package cdc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths

	// sample width, default for DATA_W
	localparam int data_w = 16;

	// gain width, default for GAIN_W
	localparam int gain_w = 8;

	// management data word, also the offset and result width
	localparam int cfg_data_w = data_w + gain_w;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register select

	typedef enum logic {
		REG_GAIN   = 1'b0,
		REG_OFFSET = 1'b1
	} cfg_reg_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bundles

	// management write, clk_a
	// gain uses only the low gain_w bits of data
	typedef struct packed {
		logic                  wr;
		cfg_reg_e              sel;
		logic [cfg_data_w-1:0] data;
	} cfg_wr_t;

	// one busy level per register, clk_a
	typedef struct packed {
		logic gain_busy;
		logic offset_busy;
	} cfg_busy_t;

	// incoming sample stream, clk_b
	typedef struct packed {
		logic              valid;
		logic [data_w-1:0] sample;
	} sample_in_t;

	// scaled result stream, clk_b
	typedef struct packed {
		logic                  valid;
		logic [cfg_data_w-1:0] result;
	} result_out_t;

endpackage

// File: design/pulse_sync.sv
`timescale 1ns/10ps

// single pulse crossing between two unrelated clocks
// source pulses must be spaced by at least a full round trip
module pulse_sync (
	input  logic clk_src,
	input  logic clk_dst,
	input  logic rst_n,
	input  logic pulse_src,
	output logic pulse_dst
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// source side

	// level that flips once per source pulse
	logic toggle_src;

	// destination chain, [0] is the metastable stage
	logic [2:0] sync_dst;

	// toggle holds its level between pulses
	// so the slower side never misses an event
	always_ff @(posedge clk_src) begin
		if (!rst_n) begin
			toggle_src <= 1'b0;
		end else if (pulse_src) begin
			toggle_src <= ~toggle_src;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// destination side

	// shift the toggle level in
	// [1] and [2] are settled copies
	always_ff @(posedge clk_dst) begin
		if (!rst_n) begin
			sync_dst <= 3'b000;
		end else begin
			sync_dst <= {sync_dst[1:0], toggle_src};
		end
	end

	// edge detect on the settled pair
	// high for exactly one destination cycle per toggle
	assign pulse_dst = sync_dst[2] ^ sync_dst[1];

endmodule

// File: design/register_sync.sv
`timescale 1ns/10ps

// carries one register from clk_a to clk_b
// update strobe goes forward, acknowledge comes back
module register_sync #(
	parameter int               WIDTH = 8,
	parameter logic [WIDTH-1:0] INIT  = '0
) (
	input  logic             clk_a,
	input  logic             clk_b,
	input  logic             rst_n,
	input  logic             en_a,
	output logic             ack_a,
	input  logic [WIDTH-1:0] reg_a,
	output logic             updated_b,
	output logic [WIDTH-1:0] reg_b
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control

	// one clk_b cycle, marks arrival of the new value
	logic update_b;

	// clk_a copy of the value, held while in flight
	logic [WIDTH-1:0] reg_a_q;

	// forward strobe
	pulse_sync u_sync_en (
		.clk_src   (clk_a),
		.clk_dst   (clk_b),
		.rst_n     (rst_n),
		.pulse_src (en_a),
		.pulse_dst (update_b)
	);

	// acknowledge back to the management side
	pulse_sync u_sync_ack (
		.clk_src   (clk_b),
		.clk_dst   (clk_a),
		.rst_n     (rst_n),
		.pulse_src (update_b),
		.pulse_dst (ack_a)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data

	// capture with the strobe edge
	// stable long before update_b can fire
	always_ff @(posedge clk_a) begin
		if (en_a) begin
			reg_a_q <= reg_a;
		end
	end

	// load on arrival, flag it one cycle later
	always_ff @(posedge clk_b) begin
		if (!rst_n) begin
			reg_b     <= INIT;
			updated_b <= 1'b0;
		end else begin
			updated_b <= update_b;
			if (update_b) begin
				reg_b <= reg_a_q;
			end
		end
	end

endmodule

// File: design/cfg_write_port.sv
`timescale 1ns/10ps

// management write decode
// one crossing in flight per register, refused writes are sticky
module cfg_write_port #(
	parameter int GAIN_W = 8
) (
	input  logic                            clk_a,
	input  logic                            rst_n,
	input  cdc_pkg::cfg_wr_t                cfg_wr,
	input  logic                            gain_ack,
	input  logic                            offset_ack,
	output logic                            gain_en,
	output logic                            offset_en,
	output logic [GAIN_W-1:0]               gain_val,
	output logic [cdc_pkg::cfg_data_w-1:0]  offset_val,
	output cdc_pkg::cfg_busy_t              cfg_busy,
	output logic                            cfg_err
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode

	// strobe aimed at each register
	logic wr_gain;
	logic wr_offset;

	// accepted writes
	logic acc_gain;
	logic acc_offset;

	// busy levels
	logic gain_busy;
	logic offset_busy;

	always_comb begin
		wr_gain   = 1'b0;
		wr_offset = 1'b0;
		unique case (cfg_wr.sel)
			cdc_pkg::REG_GAIN:   wr_gain   = cfg_wr.wr;
			cdc_pkg::REG_OFFSET: wr_offset = cfg_wr.wr;
		endcase
	end

	// only an idle register takes a write
	assign acc_gain   = wr_gain & ~gain_busy;
	assign acc_offset = wr_offset & ~offset_busy;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control state

	// en is a one-cycle pulse after acceptance
	// busy rises on the same edge, ack drops it
	always_ff @(posedge clk_a) begin
		if (!rst_n) begin
			gain_en     <= 1'b0;
			offset_en   <= 1'b0;
			gain_busy   <= 1'b0;
			offset_busy <= 1'b0;
			cfg_err     <= 1'b0;
		end else begin
			gain_en   <= acc_gain;
			offset_en <= acc_offset;
			// ack only arrives while busy, never with an accept
			if (gain_ack) begin
				gain_busy <= 1'b0;
			end else if (acc_gain) begin
				gain_busy <= 1'b1;
			end
			if (offset_ack) begin
				offset_busy <= 1'b0;
			end else if (acc_offset) begin
				offset_busy <= 1'b1;
			end
			// sticky until reset
			if ((wr_gain && gain_busy) || (wr_offset && offset_busy)) begin
				cfg_err <= 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data latches

	// gain keeps the low bits only
	always_ff @(posedge clk_a) begin
		if (acc_gain) begin
			gain_val <= cfg_wr.data[GAIN_W-1:0];
		end
		if (acc_offset) begin
			offset_val <= cfg_wr.data;
		end
	end

	assign cfg_busy.gain_busy   = gain_busy;
	assign cfg_busy.offset_busy = offset_busy;

endmodule

// File: design/scale_offset_unit.sv
`timescale 1ns/10ps

// two-stage clk_b pipeline
// result = sample * gain + offset, wrapping
module scale_offset_unit #(
	parameter int DATA_W = 16,
	parameter int GAIN_W = 8
) (
	input  logic                       clk_b,
	input  logic                       rst_n,
	input  logic [GAIN_W-1:0]          gain,
	input  logic [DATA_W+GAIN_W-1:0]   offset,
	input  cdc_pkg::sample_in_t        sample_in,
	output cdc_pkg::result_out_t       result_out
);

	// full product width, also the result width
	localparam int RES_W = DATA_W + GAIN_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage one, multiply

	// unsigned product, never overflows RES_W
	logic [RES_W-1:0] prod_d;
	logic [RES_W-1:0] prod_q;
	logic             prod_vld;

	// stage two outputs
	logic [RES_W-1:0] sum_d;
	logic [RES_W-1:0] res_q;
	logic             res_vld;

	assign prod_d = RES_W'(sample_in.sample[DATA_W-1:0]) * RES_W'(gain);

	// gain in force at this edge is the one used
	always_ff @(posedge clk_b) begin
		if (sample_in.valid) begin
			prod_q <= prod_d;
		end
		if (!rst_n) begin
			prod_vld <= 1'b0;
		end else begin
			prod_vld <= sample_in.valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage two, add offset

	// carry out dropped, mod 2**RES_W
	assign sum_d = prod_q + offset;

	// offset sampled here, one edge after gain
	always_ff @(posedge clk_b) begin
		if (prod_vld) begin
			res_q <= sum_d;
		end
		if (!rst_n) begin
			res_vld <= 1'b0;
		end else begin
			res_vld <= prod_vld;
		end
	end

	// no back-pressure, every sample appears two cycles later
	assign result_out.valid  = res_vld;
	assign result_out.result = res_q;

endmodule

// File: design/cfg_scaler_top.sv
`timescale 1ns/10ps

// config bridge and sample scaler
// management writes on clk_a, samples on clk_b
module cfg_scaler_top #(
	parameter int DATA_W = cdc_pkg::data_w,
	parameter int GAIN_W = cdc_pkg::gain_w
) (
	input  logic                   clk_a,
	input  logic                   clk_b,
	input  logic                   rst_n,
	input  cdc_pkg::cfg_wr_t       cfg_wr,
	input  cdc_pkg::sample_in_t    sample_in,
	output cdc_pkg::cfg_busy_t     cfg_busy,
	output logic                   cfg_err,
	output cdc_pkg::result_out_t   result_out
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clk_a side

	logic                           gain_en;
	logic                           offset_en;
	logic                           gain_ack;
	logic                           offset_ack;
	logic [GAIN_W-1:0]              gain_val;
	logic [cdc_pkg::cfg_data_w-1:0] offset_val;

	// clk_b copies
	logic [GAIN_W-1:0]              gain_b;
	logic [cdc_pkg::cfg_data_w-1:0] offset_b;

	cfg_write_port #(
		.GAIN_W (GAIN_W)
	) u_write_port (
		.clk_a      (clk_a),
		.rst_n      (rst_n),
		.cfg_wr     (cfg_wr),
		.gain_ack   (gain_ack),
		.offset_ack (offset_ack),
		.gain_en    (gain_en),
		.offset_en  (offset_en),
		.gain_val   (gain_val),
		.offset_val (offset_val),
		.cfg_busy   (cfg_busy),
		.cfg_err    (cfg_err)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// crossings

	// gain resets to 1, samples pass unchanged
	register_sync #(
		.WIDTH (GAIN_W),
		.INIT  (GAIN_W'(1))
	) gain_sync (
		.clk_a     (clk_a),
		.clk_b     (clk_b),
		.rst_n     (rst_n),
		.en_a      (gain_en),
		.ack_a     (gain_ack),
		.reg_a     (gain_val),
		.updated_b (),
		.reg_b     (gain_b)
	);

	register_sync #(
		.WIDTH (cdc_pkg::cfg_data_w),
		.INIT  ('0)
	) offset_sync (
		.clk_a     (clk_a),
		.clk_b     (clk_b),
		.rst_n     (rst_n),
		.en_a      (offset_en),
		.ack_a     (offset_ack),
		.reg_a     (offset_val),
		.updated_b (),
		.reg_b     (offset_b)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clk_b datapath

	scale_offset_unit #(
		.DATA_W (DATA_W),
		.GAIN_W (GAIN_W)
	) u_scaler (
		.clk_b      (clk_b),
		.rst_n      (rst_n),
		.gain       (gain_b),
		.offset     (offset_b),
		.sample_in  (sample_in),
		.result_out (result_out)
	);

endmodule

// File: verif/tb_asserts.sv
`timescale 1ns/10ps

// write port and pipeline timing rules
// bound into both modules
// inputs that belong to the other module are tied low
module tb_asserts (
	input logic       clk,
	input logic       rst_n,
	input logic [1:0] busy,
	input logic [1:0] en,
	input logic       in_vld,
	input logic       out_vld
);

	int fails = 0;

	// bit 1 gain, bit 0 offset
	for (genvar i = 0; i < 2; i++) begin : g_reg
		// a fall needs a rise at least two edges back
		busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
			$fell(busy[i]) |-> $past(busy[i], 2))
		else begin
			$error("busy bit %0d fell without having risen", i);
			fails++;
		end
		// en starts a busy period and never lands inside one
		en_idle: assert property (@(posedge clk) disable iff (!rst_n)
			en[i] |-> $rose(busy[i]))
		else begin
			$error("en pulse %0d did not start a fresh busy period", i);
			fails++;
		end
	end

	// fixed two-cycle pipeline
	vld_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_vld |-> ##2 out_vld)
	else begin
		$error("result valid did not follow sample valid by two cycles");
		fails++;
	end

endmodule

// File: verif/tb_checker.sv
`timescale 1ns/10ps

// reference model of both registers and the pipeline
module tb_checker (
	input logic                 clk_a,
	input logic                 clk_b,
	input logic                 rst_n,
	input cdc_pkg::cfg_wr_t     cfg_wr,
	input cdc_pkg::cfg_busy_t   cfg_busy,
	input logic                 cfg_err,
	input cdc_pkg::sample_in_t  sample_in,
	input cdc_pkg::result_out_t result_out
);

	localparam int res_w = cdc_pkg::cfg_data_w;

	logic [cdc_pkg::gain_w-1:0] model_gain   = 1;
	logic [res_w-1:0]           model_offset = '0;
	logic                       model_err    = 1'b0;
	logic [res_w-1:0]           expect_val;
	logic [res_w-1:0]           exp_q [$];
	int                         cyc_q [$];
	int                         cyc_b       = 0;
	int                         n_checks    = 0;
	int                         n_errors    = 0;
	int                         last_errors = 0;

	task check_eq(input string what, input logic [res_w-1:0] got, input logic [res_w-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task note_error(input string msg);
		n_errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task end_test(input int idx);
		if (n_errors == last_errors) begin
			$display("test %0d passed", idx);
		end else begin
			$display("test %0d failed with %0d errors", idx, n_errors - last_errors);
		end
		last_errors = n_errors;
	endtask

	task report_counts();
		$display("checks %0d, errors %0d", n_checks, n_errors);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clk_a, registers and sticky error

	always @(posedge clk_a) begin
		if (!rst_n) begin
			model_gain   <= 1;
			model_offset <= '0;
			model_err    <= 1'b0;
		end else begin
			// cfg_err lags the refused write by one edge
			if (cfg_err !== model_err) begin
				check_eq("cfg_err", res_w'(cfg_err), res_w'(model_err));
			end
			if (cfg_wr.wr && cfg_wr.sel == cdc_pkg::REG_GAIN) begin
				if (cfg_busy.gain_busy) model_err <= 1'b1;
				else model_gain <= cfg_wr.data[cdc_pkg::gain_w-1:0];
			end
			if (cfg_wr.wr && cfg_wr.sel == cdc_pkg::REG_OFFSET) begin
				if (cfg_busy.offset_busy) model_err <= 1'b1;
				else model_offset <= cfg_wr.data;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clk_b, results in order and two cycles late

	always @(posedge clk_b) begin
		cyc_b++;
		if (!rst_n) begin
			exp_q.delete();
			cyc_q.delete();
		end else begin
			if (result_out.valid && exp_q.size() == 0) begin
				note_error("a result came out with no sample in flight");
			end else if (result_out.valid) begin
				check_eq("result", result_out.result, exp_q.pop_front());
				if (cyc_b - cyc_q[0] != 2) begin
					note_error("result latency is not two clk_b cycles");
				end
				void'(cyc_q.pop_front());
			end
			if (sample_in.valid) begin
				expect_val = res_w'(sample_in.sample) * res_w'(model_gain) + model_offset;
				exp_q.push_back(expect_val);
				cyc_q.push_back(cyc_b);
			end
		end
	end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/10ps

module tb_top;

	typedef enum logic [1:0] {OP_SAMPLE, OP_BURST, OP_WRITE, OP_WRITE_HOLD} op_e;

	// exp holds the result for a sample
	// or the cfg_err level after a write
	typedef struct packed {
		op_e                            op;
		cdc_pkg::cfg_reg_e              sel;
		logic [cdc_pkg::cfg_data_w-1:0] data;
		logic [cdc_pkg::cfg_data_w-1:0] exp;
	} entry_t;

	localparam int clk_a_period = 100;
	localparam int n_tests      = 16;
	localparam int burst_len    = 8;

	logic                 clk_a      = 1'b0;
	logic                 clk_b      = 1'b0;
	logic                 rst_n      = 1'b0;
	cdc_pkg::cfg_wr_t     cfg_wr     = '0;
	cdc_pkg::sample_in_t  sample_in  = '0;
	cdc_pkg::cfg_busy_t   cfg_busy;
	logic                 cfg_err;
	cdc_pkg::result_out_t result_out;
	integer               seed       = 32'h0494d635;
	entry_t               tests [n_tests];

	always #(clk_a_period / 2) clk_a = ~clk_a;
	always #35 clk_b = ~clk_b;

	cfg_scaler_top #(
		.DATA_W (cdc_pkg::data_w),
		.GAIN_W (cdc_pkg::gain_w)
	) dut (.clk_a, .clk_b, .rst_n, .cfg_wr, .sample_in, .cfg_busy, .cfg_err, .result_out);

	tb_checker chk (.clk_a, .clk_b, .rst_n, .cfg_wr, .cfg_busy, .cfg_err, .sample_in, .result_out);

	// timing rules with unused inputs tied low
	bind cfg_write_port tb_asserts wp_asserts (.clk(clk_a), .rst_n(rst_n), .busy(cfg_busy),
		.en({gain_en, offset_en}), .in_vld(1'b0), .out_vld(1'b0));
	bind scale_offset_unit tb_asserts so_asserts (.clk(clk_b), .rst_n(rst_n), .busy(2'b00),
		.en(2'b00), .in_vld(sample_in.valid), .out_vld(result_out.valid));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drivers

	// one sample and a wait for its result
	task send_sample(input logic [15:0] value, input logic [23:0] exp);
		int waited;
		@(posedge clk_b);
		#5;
		sample_in = '{1'b1, value};
		@(posedge clk_b);
		#5;
		sample_in.valid = 1'b0;
		waited = 0;
		while (!result_out.valid && waited < 10) begin
			@(posedge clk_b);
			#5;
			waited++;
		end
		if (result_out.valid) begin
			chk.check_eq("table result", result_out.result, exp);
		end else begin
			chk.note_error("no result came out for a table sample");
		end
	endtask

	// back-to-back random samples with valid held high
	task send_burst();
		integer r;
		int     waited;
		for (int k = 0; k < burst_len; k++) begin
			@(posedge clk_b);
			#5;
			r = $random(seed);
			sample_in = '{1'b1, r[15:0]};
		end
		@(posedge clk_b);
		#5;
		sample_in.valid = 1'b0;
		waited = 0;
		while (chk.pending() != 0 && waited < 10) begin
			@(posedge clk_b);
			#5;
			waited++;
		end
		if (chk.pending() != 0) begin
			chk.note_error("results of a burst did not all arrive");
		end
	endtask

	// one-cycle strobe and an optional wait for both crossings
	task write_reg(input entry_t e, input logic wait_idle);
		int   waited;
		logic busy_sel;
		@(posedge clk_a);
		#5;
		cfg_wr = '{1'b1, e.sel, e.data};
		@(posedge clk_a);
		#5;
		cfg_wr.wr = 1'b0;
		chk.check_eq("cfg_err", 24'(cfg_err), e.exp);
		// selected register is busy after the strobe whether taken or refused
		busy_sel = (e.sel == cdc_pkg::REG_GAIN) ? cfg_busy.gain_busy : cfg_busy.offset_busy;
		chk.check_eq("busy after write", 24'(busy_sel), 24'(1));
		waited = 0;
		while (wait_idle && cfg_busy != '0 && waited < 20) begin
			@(posedge clk_a);
			#5;
			waited++;
		end
		if (wait_idle && cfg_busy != '0) begin
			chk.note_error("busy did not fall after a write");
		end
	endtask

	function automatic int count_assert_failures();
		return dut.u_write_port.wp_asserts.fails + dut.u_scaler.so_asserts.fails;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test table

	initial begin
		// gain 1 offset 0 after reset
		tests[0]  = '{OP_BURST, cdc_pkg::REG_GAIN, 24'h0, 24'h0};
		tests[1]  = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h001234, 24'h001234};
		tests[2]  = '{OP_WRITE, cdc_pkg::REG_GAIN, 24'h000003, 24'h0};
		tests[3]  = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h001000, 24'h003000};
		tests[4]  = '{OP_WRITE, cdc_pkg::REG_OFFSET, 24'h000100, 24'h0};
		tests[5]  = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h001000, 24'h003100};
		// upper data bits ignored for gain
		tests[6]  = '{OP_WRITE, cdc_pkg::REG_GAIN, 24'habcdff, 24'h0};
		tests[7]  = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h00ffff, 24'hff0001};
		// sum wraps at 24 bits
		tests[8]  = '{OP_WRITE, cdc_pkg::REG_OFFSET, 24'hffffff, 24'h0};
		tests[9]  = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h00ffff, 24'hfeff00};
		tests[10] = '{OP_BURST, cdc_pkg::REG_GAIN, 24'h0, 24'h0};
		// second gain write while busy is refused
		// offset write in the same window is still taken
		tests[11] = '{OP_WRITE_HOLD, cdc_pkg::REG_GAIN, 24'h000002, 24'h0};
		tests[12] = '{OP_WRITE_HOLD, cdc_pkg::REG_GAIN, 24'h000005, 24'h1};
		tests[13] = '{OP_WRITE, cdc_pkg::REG_OFFSET, 24'h000010, 24'h1};
		tests[14] = '{OP_SAMPLE, cdc_pkg::REG_GAIN, 24'h000010, 24'h000030};
		tests[15] = '{OP_BURST, cdc_pkg::REG_GAIN, 24'h0, 24'h0};

		repeat (8) @(posedge clk_a);
		#5;
		rst_n = 1'b1;
		for (int i = 0; i < n_tests; i++) begin
			case (tests[i].op)
				OP_SAMPLE: send_sample(tests[i].data[15:0], tests[i].exp);
				OP_BURST:  send_burst();
				OP_WRITE:  write_reg(tests[i], 1'b1);
				default:   write_reg(tests[i], 1'b0);
			endcase
			chk.end_test(i);
		end
		chk.report_counts();
		if (chk.n_errors == 0 && count_assert_failures() == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog allows 40 clk_a periods per table entry
	initial begin
		#(n_tests * 40 * clk_a_period);
		$display("watchdog expired before the table was finished");
		$display("Something failed");
		$finish;
	end

endmodule

// File: project.f
design/cdc_pkg.sv
design/pulse_sync.sv
design/register_sync.sv
design/cfg_write_port.sv
design/scale_offset_unit.sv
design/cfg_scaler_top.sv
verif/tb_asserts.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_top
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
